//--- Makefile
# Verilator flow for the bank 0 front end and its testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bank_arbiter.sv
`timescale 1ns/1ps
/* Fixed-priority arbiter that owns the bank request interface
   Index 0 wins over 1, 1 over 2, and so on; one access in flight at a time */
module bank_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sdram_pkg::slot_req_t [3:0] sreq,
    output sdram_pkg::slot_rsp_t [3:0] srsp,
    output sdram_pkg::bank_req_t       ba_req,
    input  sdram_pkg::bank_rsp_t       ba_rsp
);

    logic [3:0]                     gnt_q;
    logic [3:0]                     pick;
    logic                           busy_q;   // Held from grant until rdy
    logic                           rd_q;
    logic                           wr_q;
    logic [sdram_pkg::sdram_aw-1:0] addr_q;
    logic [15:0]                    din_q;
    logic [1:0]                     mask_q;
    sdram_pkg::slot_req_t           sel;

    // Loop runs from the top so the lowest index with req set wins
    always_comb begin
        pick = '0;
        sel  = '0;
        for (int i = 3; i >= 0; i--) begin
            if (sreq[i].req) begin
                pick = 4'b0001 << i;
                sel  = sreq[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q  <= '0;
            busy_q <= 1'b0;
            rd_q   <= 1'b0;
            wr_q   <= 1'b0;
        end else if (!busy_q) begin
            if (|pick) begin
                gnt_q  <= pick;
                busy_q <= 1'b1;
                rd_q   <= !sel.wr;
                wr_q   <= sel.wr;
            end
        end else begin
            if (ba_rsp.ack) begin   // Strobe drops the cycle after ack
                rd_q <= 1'b0;
                wr_q <= 1'b0;
            end
            if (ba_rsp.rdy) begin
                gnt_q  <= '0;
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && |pick) begin
            addr_q <= sel.addr;
            din_q  <= sel.din;
            mask_q <= sel.mask;
        end
    end

    assign ba_req = '{addr: addr_q, rd: rd_q, wr: wr_q, din: din_q, mask: mask_q};

    // Handshake goes back only to the granted requester
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            srsp[i].ack  = gnt_q[i] && ba_rsp.ack;
            srsp[i].rdy  = gnt_q[i] && ba_rsp.rdy;
            srsp[i].dout = ba_rsp.dout;
        end
    end

    // Bank acks only a strobe that is still up
    a_ack_on_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rsp.ack |-> busy_q && (rd_q || wr_q));

    // rdy closes an access whose strobe was already acked
    a_rdy_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rsp.rdy |-> busy_q && !rd_q && !wr_q);

endmodule

//--- project.f
sdram_pkg.sv
slot_rw.sv
slot_rom.sv
bank_arbiter.sv
prom_loader.sv
sdram_bank0.sv
tb_sdram_model.sv
tb_top.sv

//--- prom_loader.sv
`timescale 1ns/1ps
/* Download port to bank programming writes
   Pairs of bytes form one 16-bit word, placed in the main or sound ROM region */
module prom_loader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  logic                 ioctl_wr,
    input  logic [23:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    output logic                 dwnld_busy,
    output sdram_pkg::slot_req_t sreq,
    input  sdram_pkg::slot_rsp_t srsp
);

    logic                           req_q;
    logic                           wait_q;
    logic [7:0]                     low_q;    // Even byte of the word
    logic [sdram_pkg::sdram_aw-1:0] addr_q;
    logic [15:0]                    data_q;
    logic [23:0]                    snd_rel;
    logic                           pend;
    logic                           take;

    assign pend       = req_q || wait_q;
    assign take       = downloading && ioctl_wr && !pend;  // Bytes ignored while a write waits
    assign snd_rel    = ioctl_addr - sdram_pkg::snd_start;
    assign dwnld_busy = downloading || pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end else begin
            if (take && ioctl_addr[0])
                req_q <= 1'b1;
            if (req_q && srsp.ack) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (wait_q && srsp.rdy)
                wait_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (!ioctl_addr[0]) begin
                low_q <= ioctl_data;
            end else begin
                data_q <= {ioctl_data, low_q};
                if (ioctl_addr < sdram_pkg::snd_start)
                    addr_q <= sdram_pkg::rom_offset + ioctl_addr[23:1];
                else
                    addr_q <= sdram_pkg::snd_offset + snd_rel[23:1];
            end
        end
    end

    assign sreq = '{req: req_q, addr: addr_q, wr: 1'b1, din: data_q, mask: 2'b00};

endmodule

//--- sdram_bank0.sv
`timescale 1ns/1ps
/* Bank 0 front end: main RAM, main ROM and sound ROM slots plus the ROM loader
   all share one SDRAM bank through a fixed-priority arbiter */
module sdram_bank0 #(
    parameter int ram_aw = 17,
    parameter int rom_aw = 20,
    parameter int snd_aw = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Main CPU work RAM
    input  logic                 main_ram_cs,
    input  logic                 main_ram_wen,
    input  logic [ram_aw-1:0]    main_ram_addr,
    input  logic [15:0]          main_ram_din,
    input  logic [1:0]           main_ram_dsn,
    output logic                 main_ram_ok,
    output logic [15:0]          main_ram_data,

    // Main CPU ROM
    input  logic                 main_rom_cs,
    input  logic [rom_aw-1:0]    main_rom_addr,
    output logic                 main_rom_ok,
    output logic [15:0]          main_rom_data,

    // Sound CPU ROM, byte addressed
    input  logic                 snd_cs,
    input  logic [snd_aw-1:0]    snd_addr,
    output logic                 snd_ok,
    output logic [15:0]          snd_data,   // Upper byte reads zero

    // Download port
    input  logic                 downloading,
    input  logic [23:0]          ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    output logic                 dwnld_busy,

    // Bank interface
    output sdram_pkg::bank_req_t ba_req,
    input  sdram_pkg::bank_rsp_t ba_rsp
);

    sdram_pkg::slot_req_t [3:0] sreq;   // 0 loader, 1 RAM, 2 ROM, 3 sound
    sdram_pkg::slot_rsp_t [3:0] srsp;

    prom_loader u_loader (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .ioctl_wr    ( ioctl_wr     ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_data  ( ioctl_data   ),
        .dwnld_busy  ( dwnld_busy   ),
        .sreq        ( sreq[0]      ),
        .srsp        ( srsp[0]      )
    );

    // CPU slots stay quiet while the loader owns the bank
    slot_rw #(.ram_aw(ram_aw)) u_ram (
        .clk   ( clk                         ),
        .rst_n ( rst_n                       ),
        .cs    ( main_ram_cs && !dwnld_busy  ),
        .wen   ( main_ram_wen                ),
        .addr  ( main_ram_addr               ),
        .din   ( main_ram_din                ),
        .dsn   ( main_ram_dsn                ),
        .ok    ( main_ram_ok                 ),
        .dout  ( main_ram_data               ),
        .sreq  ( sreq[1]                     ),
        .srsp  ( srsp[1]                     )
    );

    slot_rom #(
        .aw        ( rom_aw                 ),
        .byte_mode ( 1'b0                   ),
        .offset    ( sdram_pkg::rom_offset  )
    ) u_rom (
        .clk   ( clk                         ),
        .rst_n ( rst_n                       ),
        .cs    ( main_rom_cs && !dwnld_busy  ),
        .addr  ( main_rom_addr               ),
        .ok    ( main_rom_ok                 ),
        .dout  ( main_rom_data               ),
        .sreq  ( sreq[2]                     ),
        .srsp  ( srsp[2]                     )
    );

    slot_rom #(
        .aw        ( snd_aw                 ),
        .byte_mode ( 1'b1                   ),
        .offset    ( sdram_pkg::snd_offset  )
    ) u_snd (
        .clk   ( clk                    ),
        .rst_n ( rst_n                  ),
        .cs    ( snd_cs && !dwnld_busy  ),
        .addr  ( snd_addr               ),
        .ok    ( snd_ok                 ),
        .dout  ( snd_data               ),
        .sreq  ( sreq[3]                ),
        .srsp  ( srsp[3]                )
    );

    bank_arbiter u_arb (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .sreq   ( sreq   ),
        .srsp   ( srsp   ),
        .ba_req ( ba_req ),
        .ba_rsp ( ba_rsp )
    );

endmodule

//--- sdram_pkg.sv
/* Shared widths, region offsets and handshake structs for SDRAM bank 0
   Slots, loader and arbiter refer to these by scoped name */
package sdram_pkg;

    localparam int sdram_aw = 23;  // Word address into the bank

    // Word bases of each region inside the bank
    localparam logic [sdram_aw-1:0] rom_offset  = 23'h00_0000;
    localparam logic [sdram_aw-1:0] wram_offset = 23'h30_0000;
    localparam logic [sdram_aw-1:0] snd_offset  = 23'h38_0000;

    // Download byte address where the sound ROM begins
    localparam logic [23:0] snd_start = 24'h10_0000;

    // Request towards the bank
    typedef struct packed {
        logic [sdram_aw-1:0] addr;
        logic                rd;
        logic                wr;
        logic [15:0]         din;
        logic [1:0]          mask;  // Set bit keeps that byte
    } bank_req_t;

    // Answer from the bank
    typedef struct packed {
        logic        ack;
        logic        dst;   // Data arriving next
        logic        rdy;   // Access finished, dout valid on reads
        logic [15:0] dout;
    } bank_rsp_t;

    // Requester to arbiter
    typedef struct packed {
        logic                req;
        logic [sdram_aw-1:0] addr;
        logic                wr;
        logic [15:0]         din;
        logic [1:0]          mask;
    } slot_req_t;

    // Arbiter back to one requester
    typedef struct packed {
        logic        ack;
        logic        rdy;
        logic [15:0] dout;
    } slot_rsp_t;

endpackage

//--- slot_rom.sv
`timescale 1ns/1ps
/* Read-only client slot with a one-entry word latch
   Serves 16-bit word clients or, in byte mode, 8-bit clients from 16-bit words */
module slot_rom #(
    parameter int                                aw        = 20,
    parameter bit                                byte_mode = 1'b0,
    parameter logic [sdram_pkg::sdram_aw-1:0]    offset    = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  logic [aw-1:0]        addr,
    output logic                 ok,
    output logic [15:0]          dout,
    output sdram_pkg::slot_req_t sreq,
    input  sdram_pkg::slot_rsp_t srsp
);

    logic [aw-1:0] waddr;    // Word index inside the region
    logic [aw-1:0] pend_q;   // Word being fetched
    logic [aw-1:0] tag_q;    // Word held in the latch
    logic [15:0]   data_q;
    logic          valid_q;
    logic          req_q;
    logic          wait_q;
    logic          hit;
    logic          done;
    logic          fresh;
    logic          start;
    logic [15:0]   word;

    assign waddr = byte_mode ? addr >> 1 : addr;
    assign hit   = valid_q && waddr == tag_q;
    assign done  = wait_q && srsp.rdy;
    assign fresh = done && waddr == pend_q;   // Bank answer for the current address
    assign start = cs && !hit && !req_q && !wait_q;
    assign word  = fresh ? srsp.dout : data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= 1'b0;
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
            ok      <= 1'b0;
        end else begin
            if (start)
                req_q <= 1'b1;
            if (req_q && srsp.ack) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (done) begin
                wait_q  <= 1'b0;
                valid_q <= 1'b1;
            end
            ok <= cs && (hit || fresh);
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            pend_q <= waddr;
        if (done) begin
            tag_q  <= pend_q;
            data_q <= srsp.dout;
        end
        if (cs && (hit || fresh)) begin
            if (byte_mode)
                dout <= {8'h00, addr[0] ? word[15:8] : word[7:0]};  // Even byte is low
            else
                dout <= word;
        end
    end

    assign sreq = '{
        req:  req_q,
        addr: offset + {{(sdram_pkg::sdram_aw-aw){1'b0}}, pend_q},
        wr:   1'b0,
        din:  16'h0000,
        mask: 2'b11
    };

    // A rdy is only expected for the fetch that was acked
    a_rdy_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
        srsp.rdy |-> wait_q);

endmodule

//--- slot_rw.sv
`timescale 1ns/1ps
/* Read/write client slot for the main CPU work RAM
   Each new cs or address becomes one bank read or one masked write */
module slot_rw #(
    parameter int ram_aw = 17
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  logic                 wen,
    input  logic [ram_aw-1:0]    addr,
    input  logic [15:0]          din,
    input  logic [1:0]           dsn,
    output logic                 ok,
    output logic [15:0]          dout,
    output sdram_pkg::slot_req_t sreq,
    input  sdram_pkg::slot_rsp_t srsp
);

    logic              req_q;
    logic              wait_q;   // Acked and waiting for rdy
    logic              wen_q;
    logic [ram_aw-1:0] addr_q;
    logic [15:0]       din_q;
    logic [1:0]        mask_q;
    logic              same;
    logic              done;
    logic              start;

    assign same  = cs && addr == addr_q;
    assign done  = wait_q && srsp.rdy;
    // New access unless one is in flight or this one already answered
    assign start = cs && !req_q && !wait_q && !(ok && same);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            ok     <= 1'b0;
        end else begin
            if (start)
                req_q <= 1'b1;
            if (req_q && srsp.ack) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end
            if (done)
                wait_q <= 1'b0;
            ok <= same && (ok || done);  // Drops as soon as cs or addr moves
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
            wen_q  <= wen;
            din_q  <= din;
            mask_q <= dsn;
        end
        if (done && !wen_q)
            dout <= srsp.dout;
    end

    assign sreq = '{
        req:  req_q,
        addr: sdram_pkg::wram_offset + {{(sdram_pkg::sdram_aw-ram_aw){1'b0}}, addr_q},
        wr:   wen_q,
        din:  din_q,
        mask: mask_q
    };

    // Ack must land on a request that is still raised
    a_ack_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        srsp.ack |-> sreq.req);

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/1ps
/* Testbench stand-in for one SDRAM bank: word memory, random ack and rdy delays
   The delays are picked by the testbench and sampled when each access starts */
module tb_sdram_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           ack_dly,  // Extra cycles before ack, 0..3
    input  logic [2:0]           rdy_dly,  // Extra cycles before rdy, 0..4
    input  sdram_pkg::bank_req_t ba_req,
    output sdram_pkg::bank_rsp_t ba_rsp
);

    logic [15:0]          mem [int];
    logic [1:0]           phase;  // 0 idle, 1 before ack, 2 before rdy
    logic [2:0]           cnt;
    logic [15:0]          word;
    sdram_pkg::bank_req_t cur;

    // Words never written read back as a mix of all address bits
    function automatic logic [15:0] read_word(input logic [22:0] a);
        if (mem.exists(int'(a)))
            return mem[int'(a)];
        return a[15:0] ^ {a[22:16], a[22:14]};
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= 2'd0;
            cnt    <= 3'd0;
            ba_rsp <= '0;
        end else begin
            ba_rsp.ack <= 1'b0;
            ba_rsp.dst <= 1'b0;
            ba_rsp.rdy <= 1'b0;
            case (phase)
                2'd0: if (ba_req.rd || ba_req.wr) begin
                    cur   <= ba_req;
                    cnt   <= {1'b0, ack_dly};
                    phase <= 2'd1;
                end
                2'd1: if (cnt == 3'd0) begin
                    ba_rsp.ack <= 1'b1;
                    cnt        <= rdy_dly + 3'd1;  // rdy 2..6 cycles after ack
                    phase      <= 2'd2;
                end else begin
                    cnt <= cnt - 3'd1;
                end
                default: if (cnt == 3'd0) begin
                    ba_rsp.rdy <= 1'b1;
                    phase      <= 2'd0;
                    word = read_word(cur.addr);
                    if (cur.rd) begin
                        ba_rsp.dout <= word;
                    end else begin
                        if (!cur.mask[0]) word[7:0] = cur.din[7:0];
                        if (!cur.mask[1]) word[15:8] = cur.din[15:8];
                        mem[int'(cur.addr)] = word;
                    end
                end else begin
                    cnt        <= cnt - 3'd1;
                    ba_rsp.dst <= cur.rd && cnt == 3'd1;  // One cycle ahead of rdy
                end
            endcase
        end
    end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps
/* Testbench for sdram_bank0 that downloads ROM data, then runs RAM, ROM and sound
   clients against a bank model and checks every answer with a reference array */
module tb_top;

    localparam int n_rom  = 100;
    localparam int n_ram  = 64;   // 16 full writes, 32 masked writes, 16 reads
    localparam int n_snd  = 64;
    localparam int n_conc = 30;   // Completed operations per client
    localparam int n_latch = 4;
    localparam int access_cycles = 16;  // Grant, ack 4, rdy 6, slot registers
    localparam int n_ops = 128 + n_rom + n_ram + n_snd + 9 * n_conc + 2 * n_latch;
    localparam int cycle_limit = 2 * n_ops * access_cycles;

    logic clk;
    logic rst_n;
    logic main_ram_cs, main_ram_wen, main_ram_ok;
    logic [16:0] main_ram_addr;
    logic [15:0] main_ram_din, main_ram_data;
    logic [1:0] main_ram_dsn;
    logic main_rom_cs, main_rom_ok;
    logic [19:0] main_rom_addr;
    logic [15:0] main_rom_data;
    logic snd_cs, snd_ok;
    logic [15:0] snd_addr, snd_data;
    logic downloading, ioctl_wr, dwnld_busy;
    logic [23:0] ioctl_addr;
    logic [7:0] ioctl_data;
    sdram_pkg::bank_req_t ba_req;
    sdram_pkg::bank_rsp_t ba_rsp;

    logic [1:0]  ack_dly = 2'd0;
    logic [2:0]  rdy_dly = 3'd0;
    logic [31:0] lfsr = 32'hc083;
    logic [15:0] ref_mem [int];   // Expected bank contents by word address
    logic [16:0] ram_addr [16];
    logic        rd_prev = 1'b0;
    int          rd_count = 0;
    int          cycles = 0;

    sdram_bank0 i_dut (.*);

    tb_sdram_model i_bank (
        .clk(clk), .rst_n(rst_n), .ack_dly(ack_dly), .rdy_dly(rdy_dly),
        .ba_req(ba_req), .ba_rsp(ba_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [15:0] ref_word(input logic [22:0] wa);
        return ref_mem.exists(int'(wa)) ? ref_mem[int'(wa)] : 16'h0000;
    endfunction

    // Set mask bit keeps the old byte
    function automatic void ref_write(input logic [22:0] wa, input logic [15:0] d,
                                      input logic [1:0] m);
        logic [15:0] w;
        w = ref_word(wa);
        if (!m[0]) w[7:0] = d[7:0];
        if (!m[1]) w[15:8] = d[15:8];
        ref_mem[int'(wa)] = w;
    endfunction

    function automatic logic [22:0] download_word(input logic [23:0] ba);
        logic [23:0] rel;
        rel = ba - sdram_pkg::snd_start;
        if (ba < sdram_pkg::snd_start)
            return sdram_pkg::rom_offset + 23'(ba >> 1);
        return sdram_pkg::snd_offset + 23'(rel >> 1);
    endfunction

    function automatic logic [15:0] snd_expect(input logic [15:0] a);
        logic [15:0] w;
        w = ref_word(sdram_pkg::snd_offset + 23'(a >> 1));
        return {8'h00, a[0] ? w[15:8] : w[7:0]};  // Odd address is the high byte
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // Close out the RAM access that just raised ok
    task automatic ram_finish();
        logic [22:0] wa;
        wa = sdram_pkg::wram_offset + 23'(main_ram_addr);
        if (main_ram_wen)
            ref_write(wa, main_ram_din, main_ram_dsn);
        else
            check_value("main_ram_data", main_ram_data, ref_word(wa));
    endtask

    task automatic ram_op(input logic wen, input logic [16:0] a, input logic [15:0] d,
                          input logic [1:0] m);
        main_ram_wen  = wen;
        main_ram_addr = a;
        main_ram_din  = d;
        main_ram_dsn  = m;
        main_ram_cs   = 1'b1;
        do tick(); while (!main_ram_ok);
        ram_finish();
        main_ram_cs = 1'b0;
        tick();
    endtask

    task automatic rom_read(input logic [19:0] a);
        main_rom_cs   = 1'b1;
        main_rom_addr = a;
        do tick(); while (!main_rom_ok);
        check_value("main_rom_data", main_rom_data, ref_word(23'(a)));
        main_rom_cs = 1'b0;
        tick();
    endtask

    task automatic snd_read(input logic [15:0] a);
        snd_cs   = 1'b1;
        snd_addr = a;
        do tick(); while (!snd_ok);
        check_value("snd_data", snd_data, snd_expect(a));
        snd_cs = 1'b0;
        tick();
    endtask

    // One word per byte pair and a wait for the loader write to drain
    task automatic download_region(input logic [23:0] base);
        for (int i = 0; i < 64; i++) begin
            downloading = 1'b1;
            ioctl_wr    = 1'b1;
            ioctl_addr  = base + 24'(i);
            ioctl_data  = 8'(rand_bits(8));
            ref_write(download_word(ioctl_addr), {ioctl_data, ioctl_data},
                      ioctl_addr[0] ? 2'b01 : 2'b10);
            tick();
            ioctl_wr = 1'b0;
            if (i % 2 == 1) begin
                downloading = 1'b0;
                do tick(); while (dwnld_busy);
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        ack_dly = 2'(rand_bits(2));
        rdy_dly = 3'(rand_bits(3) % 5);
    end

    always @(posedge clk) begin
        if (ba_req.rd && !rd_prev)
            rd_count++;
        rd_prev = ba_req.rd;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: clients still waiting after %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int ram_n, rom_n, snd_n, seen;
        logic [19:0] a;
        rst_n = 1'b0;
        main_ram_cs = 1'b0;
        main_ram_wen = 1'b0;
        main_ram_addr = '0;
        main_ram_din = '0;
        main_ram_dsn = 2'b11;
        main_rom_cs = 1'b0;
        main_rom_addr = '0;
        snd_cs = 1'b0;
        snd_addr = '0;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        tick();
        check_value("ba_req.rd", ba_req.rd, 0);
        check_value("ba_req.wr", ba_req.wr, 0);
        check_value("ok outputs", {main_ram_ok, main_rom_ok, snd_ok}, 0);
        check_value("dwnld_busy", dwnld_busy, 0);

        download_region(24'h00_0200);                    // ROM words 0x100..0x11f
        download_region(sdram_pkg::snd_start + 24'h80);  // Sound bytes 0x80..0xbf

        for (int i = 0; i < n_rom; i++)
            rom_read(20'h00100 + 20'(rand_bits(5)));

        for (int i = 0; i < 16; i++) begin
            ram_addr[i] = 17'(rand_bits(17));
            ram_op(1'b1, ram_addr[i], 16'(rand_bits(16)), 2'b00);
        end
        for (int i = 0; i < 32; i++)
            ram_op(1'b1, ram_addr[rand_bits(4)], 16'(rand_bits(16)), 2'(rand_bits(2)));
        for (int i = 0; i < 16; i++)
            ram_op(1'b0, ram_addr[i], 16'h0000, 2'b11);

        for (int i = 0; i < n_snd; i++)
            snd_read(16'h0080 + 16'(rand_bits(6)));

        // All three clients at once and each restarts as soon as it is answered
        ram_n = 0;
        rom_n = 0;
        snd_n = 0;
        while (ram_n < n_conc || rom_n < n_conc || snd_n < n_conc) begin
            if (main_ram_cs && main_ram_ok) begin
                ram_finish();
                main_ram_cs = 1'b0;
                ram_n++;
            end else if (!main_ram_cs && ram_n < n_conc) begin
                main_ram_wen  = rand_bits(1) == 1;
                main_ram_addr = ram_addr[rand_bits(4)];
                main_ram_din  = 16'(rand_bits(16));
                main_ram_dsn  = 2'(rand_bits(2));
                main_ram_cs   = 1'b1;
            end
            if (main_rom_cs && main_rom_ok) begin
                check_value("main_rom_data", main_rom_data, ref_word(23'(main_rom_addr)));
                main_rom_cs = 1'b0;
                rom_n++;
            end else if (!main_rom_cs && rom_n < n_conc) begin
                main_rom_addr = 20'h00100 + 20'(rand_bits(5));
                main_rom_cs   = 1'b1;
            end
            if (snd_cs && snd_ok) begin
                check_value("snd_data", snd_data, snd_expect(snd_addr));
                snd_cs = 1'b0;
                snd_n++;
            end else if (!snd_cs && snd_n < n_conc) begin
                snd_addr = 16'h0080 + 16'(rand_bits(6));
                snd_cs   = 1'b1;
            end
            tick();
        end
        tick();

        // Same address again must come from the latch
        for (int i = 0; i < n_latch; i++) begin
            a = 20'h00100 + 20'(rand_bits(5));
            rom_read(a);
            seen = rd_count;
            main_rom_cs   = 1'b1;
            main_rom_addr = a;
            tick();
            check_value("main_rom_ok", main_rom_ok, 1);
            check_value("main_rom_data", main_rom_data, ref_word(23'(a)));
            main_rom_cs = 1'b0;
            repeat (3) tick();  // Long enough for a stray fetch to show on ba_req.rd
            check_value("ba_req.rd pulses", rd_count, seen);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
